// File: csr_cmd_queue.sv
// CSR command queue
`timescale 1ns/1ps
`default_nettype none

module csr_cmd_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_push,
  input  wire csr_pkg::csr_cmd_t i_cmd,
  input  wire logic              i_pop,
  output logic                   o_valid,
  output csr_pkg::csr_cmd_t      o_cmd,
  output logic                   o_credit
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  csr_pkg::csr_cmd_t mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              empty;
  logic              do_push;
  logic              do_pop;

  // pointers wrap at the depth, which need not be a power of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full    = (count == CNT_W'(QUEUE_DEPTH));
  assign empty   = (count == '0);
  assign do_push = i_push && !full;
  assign do_pop  = i_pop && !empty;

  assign o_valid = !empty;
  assign o_cmd   = mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_cmd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit goes back to the sender for every entry that leaves.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_credit <= 1'b0;
    end else begin
      o_credit <= do_pop;
    end
  end

  // a sender that honours its credits never pushes into a full queue.
  a_push_full: assert property (
    @(posedge i_clk) disable iff (i_rst) !(i_push && full)
  ) else $error("push into full CSR command queue");

endmodule

`default_nettype wire

// File: csr_exec.sv
// CSR command executor
`timescale 1ns/1ps
`default_nettype none

module csr_exec #(
  parameter int XLEN_P = csr_pkg::XLEN
) (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_cmd_valid,
  input  wire csr_pkg::csr_cmd_t i_cmd,
  output logic                   o_pop,
  output logic                   o_rsp_valid,
  output logic [XLEN_P-1:0]      o_rsp_rdata,
  output logic                   o_redirect_valid,
  output logic [XLEN_P-1:0]      o_redirect_pc,
  csr_if.exec                    csr
);

  logic              is_rmw;
  logic              is_ecall;
  logic              is_mret;
  logic [XLEN_P-1:0] src;
  logic [XLEN_P-1:0] old_val;
  logic [XLEN_P-1:0] new_val;

  // ========================================
  // decode
  // ========================================

  // every queued command is taken at once, so one leaves per cycle.
  assign o_pop = i_cmd_valid;

  assign is_rmw   = i_cmd_valid && csr_pkg::is_rmw(i_cmd.op);
  assign is_ecall = i_cmd_valid && (i_cmd.op == csr_pkg::ECALL);
  assign is_mret  = i_cmd_valid && (i_cmd.op == csr_pkg::MRET);

  assign src     = XLEN_P'(i_cmd.src);
  assign old_val = csr.rdata;

  // set and clear write back even with a zero source.
  always_comb begin
    case (i_cmd.op)
      csr_pkg::CSRRW: new_val = src;
      csr_pkg::CSRRS: new_val = old_val | src;
      csr_pkg::CSRRC: new_val = old_val & ~src;
      default:        new_val = old_val;
    endcase
  end

  // ========================================
  // register file access
  // ========================================

  assign csr.ren   = is_rmw;
  assign csr.raddr = i_cmd.addr;
  assign csr.wen   = is_rmw;
  assign csr.waddr = i_cmd.addr;
  assign csr.wdata = new_val;
  assign csr.ecall = is_ecall;
  assign csr.mret  = is_mret;
  assign csr.epc   = XLEN_P'(i_cmd.pc);

  // ========================================
  // response
  // ========================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_valid      <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else begin
      o_rsp_valid      <= i_cmd_valid;
      o_redirect_valid <= is_ecall || is_mret;
    end
  end

  // mtvec and mepc are sampled before this edge's trap update lands.
  always_ff @(posedge i_clk) begin
    if (i_cmd_valid) begin
      o_rsp_rdata <= is_rmw ? old_val : '0;
      if (is_ecall) begin
        o_redirect_pc <= csr.mtvec;
      end else if (is_mret) begin
        o_redirect_pc <= csr.mepc;
      end else begin
        o_redirect_pc <= '0;
      end
    end
  end

  // traps carry no CSR read data back to retire.
  a_redirect_rdata: assert property (
    @(posedge i_clk) disable iff (i_rst)
      o_redirect_valid |-> (o_rsp_valid && (o_rsp_rdata == '0))
  ) else $error("redirect response with nonzero rdata");

endmodule

`default_nettype wire

// File: csr_if.sv
// Executor to CSR register file link
`timescale 1ns/1ps
`default_nettype none

interface csr_if #(
  parameter int XLEN_P = csr_pkg::XLEN
) ();

  // rdata is combinational and reads zero while ren is low.
  logic                           ren;
  logic [csr_pkg::CSR_ADDR_W-1:0] raddr;
  logic [XLEN_P-1:0]              rdata;

  // a write takes effect at the next edge.
  logic                           wen;
  logic [csr_pkg::CSR_ADDR_W-1:0] waddr;
  logic [XLEN_P-1:0]              wdata;

  // trap side.
  logic                           ecall;
  logic                           mret;
  logic [XLEN_P-1:0]              epc;
  logic [XLEN_P-1:0]              mtvec;
  logic [XLEN_P-1:0]              mepc;

  modport exec (
    output ren, raddr, wen, waddr, wdata, ecall, mret, epc,
    input  rdata, mtvec, mepc
  );

  modport regs (
    input  ren, raddr, wen, waddr, wdata, ecall, mret, epc,
    output rdata, mtvec, mepc
  );

endinterface

`default_nettype wire

// File: csr_pkg.sv
// CSR subsystem definitions
`default_nettype none

package csr_pkg;

  // ========================================
  // widths
  // ========================================

  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;

  // ========================================
  // command opcodes
  // ========================================

  typedef enum logic [2:0] {
    CSRRW = 3'd0,
    CSRRS = 3'd1,
    CSRRC = 3'd2,
    ECALL = 3'd3,
    MRET  = 3'd4
  } csr_op_e;

  // ========================================
  // machine-mode CSR map
  // ========================================

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

  // mstatus holds mpp = 3 and sxl/uxl = 2 out of reset and after mret.
  localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

  // environment call from M-mode.
  localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 64'd11;

  // ========================================
  // command word
  // ========================================

  // one pipeline command of 143 bits.
  typedef struct packed {
    csr_op_e               op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       src;
    logic [XLEN-1:0]       pc;
  } csr_cmd_t;

  // true for the three read-modify-write opcodes.
  function automatic logic is_rmw(input csr_op_e op);
    logic result;
    result = (op == CSRRW) || (op == CSRRS) || (op == CSRRC);
    return result;
  endfunction

endpackage

`default_nettype wire

// File: csr_regfile.sv
// Machine-mode CSR registers
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
  parameter int XLEN_P = csr_pkg::XLEN
) (
  input wire logic i_clk,
  input wire logic i_rst,
  csr_if.regs      csr
);

  logic [XLEN_P-1:0] mstatus;
  logic [XLEN_P-1:0] mtvec;
  logic [XLEN_P-1:0] mepc;
  logic [XLEN_P-1:0] mcause;
  logic [XLEN_P-1:0] mscratch;
  logic [XLEN_P-1:0] rd_mux;

  // ========================================
  // read side
  // ========================================

  // unknown addresses read as zero.
  always_comb begin
    case (csr.raddr)
      csr_pkg::CSR_MSTATUS:  rd_mux = mstatus;
      csr_pkg::CSR_MTVEC:    rd_mux = mtvec;
      csr_pkg::CSR_MEPC:     rd_mux = mepc;
      csr_pkg::CSR_MCAUSE:   rd_mux = mcause;
      csr_pkg::CSR_MSCRATCH: rd_mux = mscratch;
      default:               rd_mux = '0;
    endcase
  end

  assign csr.rdata = csr.ren ? rd_mux : '0;
  assign csr.mtvec = mtvec;
  assign csr.mepc  = mepc;

  // ========================================
  // update side
  // ========================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus  <= XLEN_P'(csr_pkg::MSTATUS_RESET);
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (csr.wen) begin
      // writes to unknown addresses fall through and are dropped.
      case (csr.waddr)
        csr_pkg::CSR_MSTATUS:  mstatus  <= csr.wdata;
        csr_pkg::CSR_MTVEC:    mtvec    <= csr.wdata;
        csr_pkg::CSR_MEPC:     mepc     <= csr.wdata;
        csr_pkg::CSR_MCAUSE:   mcause   <= csr.wdata;
        csr_pkg::CSR_MSCRATCH: mscratch <= csr.wdata;
        default: begin
        end
      endcase
    end else if (csr.ecall) begin
      mepc   <= csr.epc;
      mcause <= XLEN_P'(csr_pkg::MCAUSE_ECALL_M);
    end else if (csr.mret) begin
      // no privilege stack here, so mret just puts mstatus back.
      mstatus <= XLEN_P'(csr_pkg::MSTATUS_RESET);
    end
  end

  // the executor never issues a trap and a write in the same cycle.
  a_trap_excl: assert property (
    @(posedge i_clk) disable iff (i_rst)
      (csr.ecall || csr.mret) |-> (!csr.wen && !(csr.ecall && csr.mret))
  ) else $error("CSR trap collides with a write or another trap");

endmodule

`default_nettype wire

// File: csr_top.sv
// CSR and trap subsystem top
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic                           i_clk,
  input  wire logic                           i_rst,
  input  wire logic                           i_cmd_valid,
  input  wire csr_pkg::csr_op_e               i_cmd_op,
  input  wire logic [csr_pkg::CSR_ADDR_W-1:0] i_cmd_addr,
  input  wire logic [csr_pkg::XLEN-1:0]       i_cmd_src,
  input  wire logic [csr_pkg::XLEN-1:0]       i_cmd_pc,
  output logic                                o_credit,
  output logic                                o_rsp_valid,
  output logic [csr_pkg::XLEN-1:0]            o_rsp_rdata,
  output logic                                o_redirect_valid,
  output logic [csr_pkg::XLEN-1:0]            o_redirect_pc
);

  localparam int XLEN_P = csr_pkg::XLEN;

  csr_pkg::csr_cmd_t in_cmd;
  csr_pkg::csr_cmd_t deq_cmd;
  logic              deq_valid;
  logic              deq_pop;

  assign in_cmd.op   = i_cmd_op;
  assign in_cmd.addr = i_cmd_addr;
  assign in_cmd.src  = i_cmd_src;
  assign in_cmd.pc   = i_cmd_pc;

  csr_if #(.XLEN_P(XLEN_P)) u_csr_if ();

  csr_cmd_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (i_cmd_valid),
    .i_cmd    (in_cmd),
    .i_pop    (deq_pop),
    .o_valid  (deq_valid),
    .o_cmd    (deq_cmd),
    .o_credit (o_credit)
  );

  csr_exec #(.XLEN_P(XLEN_P)) u_exec (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_cmd_valid      (deq_valid),
    .i_cmd            (deq_cmd),
    .o_pop            (deq_pop),
    .o_rsp_valid      (o_rsp_valid),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_redirect_valid (o_redirect_valid),
    .o_redirect_pc    (o_redirect_pc),
    .csr              (u_csr_if.exec)
  );

  csr_regfile #(.XLEN_P(XLEN_P)) u_regfile (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .csr   (u_csr_if.regs)
  );

endmodule

`default_nettype wire

// File: filelist.f
csr_pkg.sv
csr_if.sv
csr_cmd_queue.sv
csr_regfile.sv
csr_exec.sv
csr_top.sv
tb_csr_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_csr_top -f filelist.f \
  && ./obj_dir/Vtb_csr_top | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"

// File: tb_csr_top.sv
// CSR subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

  localparam int QUEUE_DEPTH    = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int N_DIRECTED     = 16;
  localparam int N_RANDOM       = 400;
  localparam int N_CMDS         = N_DIRECTED + N_RANDOM + QUEUE_DEPTH;
  localparam int TIMEOUT_CYCLES = N_CMDS * 20 + RESET_CYCLES;

  localparam logic [63:0] EXP_MSTATUS_RESET = 64'h0000_000a_0000_1800;
  localparam logic [63:0] EXP_CAUSE_ECALL   = 64'd11;

  localparam logic [11:0] A_MSTATUS  = 12'h300;
  localparam logic [11:0] A_MTVEC    = 12'h305;
  localparam logic [11:0] A_MSCRATCH = 12'h340;
  localparam logic [11:0] A_MEPC     = 12'h341;
  localparam logic [11:0] A_MCAUSE   = 12'h342;
  localparam logic [11:0] A_UNKNOWN  = 12'h7c0;

  logic             i_clk;
  logic             i_rst;
  logic             i_cmd_valid;
  csr_pkg::csr_op_e i_cmd_op;
  logic [11:0]      i_cmd_addr;
  logic [63:0]      i_cmd_src;
  logic [63:0]      i_cmd_pc;
  logic             o_credit;
  logic             o_rsp_valid;
  logic [63:0]      o_rsp_rdata;
  logic             o_redirect_valid;
  logic [63:0]      o_redirect_pc;

  logic [11:0] addr_list [6];
  logic [31:0] lcg_state;
  int          credits;
  int          credit_pulses;
  int          sent;
  int          errors;

  // reference copies of the five CSRs.
  logic [63:0] m_mstatus;
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mscratch;

  // expected responses in command order.
  logic [63:0] exp_rdata_q [$];
  logic        exp_redir_q [$];
  logic [63:0] exp_pc_q [$];

  csr_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_cmd_valid      (i_cmd_valid),
    .i_cmd_op         (i_cmd_op),
    .i_cmd_addr       (i_cmd_addr),
    .i_cmd_src        (i_cmd_src),
    .i_cmd_pc         (i_cmd_pc),
    .o_credit         (o_credit),
    .o_rsp_valid      (o_rsp_valid),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_redirect_valid (o_redirect_valid),
    .o_redirect_pc    (o_redirect_pc)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // ========================================
  // helpers
  // ========================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic csr_pkg::csr_op_e pick_op(input logic [2:0] sel);
    csr_pkg::csr_op_e op;
    case (sel)
      3'd0, 3'd1: op = csr_pkg::CSRRW;
      3'd2, 3'd3: op = csr_pkg::CSRRS;
      3'd4, 3'd5: op = csr_pkg::CSRRC;
      3'd6:       op = csr_pkg::ECALL;
      default:    op = csr_pkg::MRET;
    endcase
    return op;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [63:0] model_read(input logic [11:0] addr);
    logic [63:0] val;
    case (addr)
      A_MSTATUS:  val = m_mstatus;
      A_MTVEC:    val = m_mtvec;
      A_MEPC:     val = m_mepc;
      A_MCAUSE:   val = m_mcause;
      A_MSCRATCH: val = m_mscratch;
      default:    val = '0;
    endcase
    return val;
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      A_MSTATUS:  m_mstatus = val;
      A_MTVEC:    m_mtvec = val;
      A_MEPC:     m_mepc = val;
      A_MCAUSE:   m_mcause = val;
      A_MSCRATCH: m_mscratch = val;
      default: begin
      end
    endcase
  endtask

  task automatic expect_rsp(input logic [63:0] rdata, input logic redir,
                            input logic [63:0] pc);
    exp_rdata_q.push_back(rdata);
    exp_redir_q.push_back(redir);
    exp_pc_q.push_back(pc);
  endtask

  task automatic apply_model(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                             input logic [63:0] src, input logic [63:0] pc);
    logic [63:0] old_val;
    old_val = model_read(addr);
    case (op)
      csr_pkg::CSRRW: begin
        model_write(addr, src);
        expect_rsp(old_val, 1'b0, '0);
      end
      csr_pkg::CSRRS: begin
        model_write(addr, old_val | src);
        expect_rsp(old_val, 1'b0, '0);
      end
      csr_pkg::CSRRC: begin
        model_write(addr, old_val & ~src);
        expect_rsp(old_val, 1'b0, '0);
      end
      csr_pkg::ECALL: begin
        expect_rsp('0, 1'b1, m_mtvec);
        m_mepc = pc;
        m_mcause = EXP_CAUSE_ECALL;
      end
      default: begin
        expect_rsp('0, 1'b1, m_mepc);
        m_mstatus = EXP_MSTATUS_RESET;
      end
    endcase
  endtask

  // sends one command and holds it back while no credit is left.
  task automatic send_cmd(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                          input logic [63:0] src, input logic [63:0] pc);
    @(posedge i_clk);
    while (credits == 0) begin
      i_cmd_valid <= 1'b0;
      @(posedge i_clk);
    end
    i_cmd_valid <= 1'b1;
    i_cmd_op    <= op;
    i_cmd_addr  <= addr;
    i_cmd_src   <= src;
    i_cmd_pc    <= pc;
    credits = credits - 1;
    sent = sent + 1;
    apply_model(op, addr, src, pc);
  endtask

  task automatic idle_cycle();
    @(posedge i_clk);
    i_cmd_valid <= 1'b0;
  endtask

  // ========================================
  // response and credit monitor
  // ========================================

  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_credit) begin
        credits = credits + 1;
        credit_pulses = credit_pulses + 1;
        if (credits > QUEUE_DEPTH) begin
          errors = errors + 1;
          $display("credit returned with no command outstanding at %0t", $time);
        end
      end
      if (o_rsp_valid) begin
        if (exp_rdata_q.size() == 0) begin
          errors = errors + 1;
          $display("response arrived with no command outstanding at %0t", $time);
        end else begin
          check_value("o_rsp_rdata", o_rsp_rdata, exp_rdata_q.pop_front());
          check_value("o_redirect_valid", 64'(o_redirect_valid), 64'(exp_redir_q[0]));
          if (exp_redir_q.pop_front()) begin
            check_value("o_redirect_pc", o_redirect_pc, exp_pc_q[0]);
          end
          void'(exp_pc_q.pop_front());
        end
      end else if (o_redirect_valid) begin
        errors = errors + 1;
        $display("redirect raised without a response at %0t", $time);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge i_clk);
    $display("watchdog expired after %0d cycles with responses outstanding", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ========================================
  // stimulus
  // ========================================

  initial begin
    logic [31:0] r;
    int          idx;
    logic [63:0] src;
    logic [63:0] pc;
    i_rst = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd_op = csr_pkg::CSRRW;
    i_cmd_addr = '0;
    i_cmd_src = '0;
    i_cmd_pc = '0;
    lcg_state = 32'd53129;
    credits = QUEUE_DEPTH;
    credit_pulses = 0;
    sent = 0;
    errors = 0;
    m_mstatus = EXP_MSTATUS_RESET;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mscratch = '0;
    addr_list = '{A_MSTATUS, A_MTVEC, A_MEPC, A_MCAUSE, A_MSCRATCH, A_UNKNOWN};
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst <= 1'b0;

    // reset values come first, followed by a trap round trip and the unknown address.
    for (int i = 0; i < 6; i++) begin
      send_cmd(csr_pkg::CSRRS, addr_list[i], '0, '0);
    end
    send_cmd(csr_pkg::CSRRW, A_MTVEC, 64'h0000_0000_8000_0100, '0);
    send_cmd(csr_pkg::CSRRW, A_MSTATUS, 64'h0000_0000_0000_0088, '0);
    send_cmd(csr_pkg::ECALL, '0, '0, 64'h0000_0000_8000_2000);
    send_cmd(csr_pkg::CSRRS, A_MEPC, '0, '0);
    send_cmd(csr_pkg::CSRRS, A_MCAUSE, '0, '0);
    send_cmd(csr_pkg::CSRRW, A_MEPC, 64'h0000_0000_8000_3000, '0);
    send_cmd(csr_pkg::MRET, '0, '0, '0);
    send_cmd(csr_pkg::CSRRS, A_MSTATUS, '0, '0);
    send_cmd(csr_pkg::CSRRW, A_UNKNOWN, 64'hdead_beef_0000_0001, '0);
    send_cmd(csr_pkg::CSRRS, A_UNKNOWN, '0, '0);

    for (int n = 0; n < N_RANDOM; n++) begin
      r = lcg_next();
      if (r[31:30] == 2'b00) begin
        idle_cycle();
      end
      idx = int'(r[23:8]) % 6;
      src = {lcg_next(), lcg_next()};
      if (r[29:27] == 3'd0) begin
        src = '0;
      end
      pc = {lcg_next(), lcg_next()};
      send_cmd(pick_op(r[26:24]), addr_list[idx], src, pc);
    end

    // all credits come home before a burst at full rate.
    while (credits != QUEUE_DEPTH) begin
      idle_cycle();
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      send_cmd(csr_pkg::CSRRW, A_MSCRATCH, 64'(i) + 64'h100, '0);
    end
    while (exp_rdata_q.size() != 0) begin
      idle_cycle();
    end
    repeat (4) idle_cycle();

    check_value("credit_pulses", 64'(credit_pulses), 64'(sent));
    $display("errors: %0d, commands: %0d, credits returned: %0d",
             errors, sent, credit_pulses);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
